// ==== rtl/wb_pkg.sv ====
// Bus widths, address map, timer register offsets and
// slice state encodings for the Wishbone subsystem
`default_nettype none

package wb_pkg;

    // Bus widths
    localparam int ADR_WIDTH = 12;
    localparam int DAT_WIDTH = 32;
    localparam int SEL_WIDTH = DAT_WIDTH / 8;

    // Address map, word addresses, inclusive ranges
    localparam logic [ADR_WIDTH-1:0] RAM_BASE = 12'h000;
    localparam logic [ADR_WIDTH-1:0] RAM_LAST = 12'h0FF;
    localparam logic [ADR_WIDTH-1:0] TMR_BASE = 12'h100;
    localparam logic [ADR_WIDTH-1:0] TMR_LAST = 12'h103;

    localparam int RAM_DEPTH = 256;

    // Timer registers, selected by the low two address bits
    localparam logic [1:0] TMR_CTRL  = 2'd0;
    localparam logic [1:0] TMR_COUNT = 2'd1;
    localparam logic [1:0] TMR_CMP   = 2'd2;
    localparam logic [1:0] TMR_STAT  = 2'd3;

    // Bits within CTRL and STAT
    localparam int CTRL_EN_BIT     = 0;
    localparam int CTRL_RELOAD_BIT = 1;
    localparam int STAT_MATCH_BIT  = 0;

    // Request slice states
    localparam logic SLICE_IDLE = 1'b0;
    localparam logic SLICE_WAIT = 1'b1;

endpackage

`default_nettype wire

// ==== rtl/wb_if.sv ====
// Wishbone classic interface with master and slave modports
`timescale 1ns/100ps
`default_nettype none

interface wb_if;

    logic [wb_pkg::ADR_WIDTH-1:0] adr;
    logic [wb_pkg::DAT_WIDTH-1:0] dat_w;
    logic [wb_pkg::DAT_WIDTH-1:0] dat_r;
    logic [wb_pkg::SEL_WIDTH-1:0] sel;
    logic                         we;
    logic                         stb;
    logic                         ack;

    modport master (
        output adr,
        output dat_w,
        output sel,
        output we,
        output stb,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  adr,
        input  dat_w,
        input  sel,
        input  we,
        input  stb,
        output dat_r,
        output ack
    );

endinterface

`default_nettype wire

// ==== rtl/wb_req_slice.sv ====
// Request slice: registers one Wishbone request downstream
// and returns a registered acknowledge upstream
`timescale 1ns/100ps
`default_nettype none

module wb_req_slice (
    input  wire logic                         clk,
    input  wire logic                         rst_n_i,
    input  wire logic [wb_pkg::ADR_WIDTH-1:0] s_adr_i,
    input  wire logic [wb_pkg::DAT_WIDTH-1:0] s_dat_i,
    input  wire logic [wb_pkg::SEL_WIDTH-1:0] s_sel_i,
    input  wire logic                         s_we_i,
    input  wire logic                         s_stb_i,
    output logic      [wb_pkg::DAT_WIDTH-1:0] s_dat_o,
    output logic                              s_ack_o,
    wb_if.master                              m
);

    logic                         state_q;
    logic                         stb_q;
    logic [wb_pkg::ADR_WIDTH-1:0] adr_q;
    logic [wb_pkg::DAT_WIDTH-1:0] dat_q;
    logic [wb_pkg::SEL_WIDTH-1:0] sel_q;
    logic                         we_q;

    // Control path
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= wb_pkg::SLICE_IDLE;
            stb_q   <= 1'b0;
            s_ack_o <= 1'b0;
        end else begin
            s_ack_o <= 1'b0;
            case (state_q)
                wb_pkg::SLICE_IDLE: begin
                    // Master still holds stb while our ack is out
                    if (s_stb_i && !s_ack_o) begin
                        stb_q   <= 1'b1;
                        state_q <= wb_pkg::SLICE_WAIT;
                    end
                end
                default: begin
                    if (m.ack) begin
                        stb_q   <= 1'b0;
                        s_ack_o <= 1'b1;
                        state_q <= wb_pkg::SLICE_IDLE;
                    end
                end
            endcase
        end
    end

    // Request fields and returned read data
    always_ff @(posedge clk) begin
        if (state_q == wb_pkg::SLICE_IDLE && s_stb_i && !s_ack_o) begin
            adr_q <= s_adr_i;
            dat_q <= s_dat_i;
            sel_q <= s_sel_i;
            we_q  <= s_we_i;
        end
        if (state_q == wb_pkg::SLICE_WAIT && m.ack) begin
            s_dat_o <= m.dat_r;
        end
    end

    assign m.adr   = adr_q;
    assign m.dat_w = dat_q;
    assign m.sel   = sel_q;
    assign m.we    = we_q;
    assign m.stb   = stb_q;

endmodule

`default_nettype wire

// ==== rtl/wb_addr_decoder.sv ====
// Address decoder routing one Wishbone slave port to the RAM
// and timer ranges, with an acknowledge for unmapped addresses
`timescale 1ns/100ps
`default_nettype none

module wb_addr_decoder (
    wb_if.slave  s,
    wb_if.master m_ram,
    wb_if.master m_tmr
);

    logic ram_hit;
    logic tmr_hit;

    function automatic logic in_range(
        input logic [wb_pkg::ADR_WIDTH-1:0] adr,
        input logic [wb_pkg::ADR_WIDTH-1:0] base,
        input logic [wb_pkg::ADR_WIDTH-1:0] last
    );
        in_range = (adr >= base) && (adr <= last);
    endfunction

    assign ram_hit = in_range(s.adr, wb_pkg::RAM_BASE, wb_pkg::RAM_LAST);
    assign tmr_hit = in_range(s.adr, wb_pkg::TMR_BASE, wb_pkg::TMR_LAST);

    // Request fields fan out to both targets
    assign m_ram.adr   = s.adr;
    assign m_ram.dat_w = s.dat_w;
    assign m_ram.sel   = s.sel;
    assign m_ram.we    = s.we;
    assign m_ram.stb   = s.stb && ram_hit;

    assign m_tmr.adr   = s.adr;
    assign m_tmr.dat_w = s.dat_w;
    assign m_tmr.sel   = s.sel;
    assign m_tmr.we    = s.we;
    assign m_tmr.stb   = s.stb && tmr_hit;

    // Return path; unmapped requests ack at once with zero data
    always_comb begin
        s.dat_r = '0;
        s.ack   = s.stb;
        if (m_ram.stb) begin
            s.dat_r = m_ram.dat_r;
            s.ack   = m_ram.ack;
        end else if (m_tmr.stb) begin
            s.dat_r = m_tmr.dat_r;
            s.ack   = m_tmr.ack;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/wb_scratch_ram.sv ====
// Scratch RAM with byte-select writes and registered acknowledge
`timescale 1ns/100ps
`default_nettype none

module wb_scratch_ram (
    input  wire logic clk,
    input  wire logic rst_n_i,
    wb_if.slave       s
);

    logic [wb_pkg::DAT_WIDTH-1:0] mem [wb_pkg::RAM_DEPTH];
    logic [wb_pkg::DAT_WIDTH-1:0] rd_q;
    logic                         ack_q;
    logic                         wr_en;

    // One write per request, in the first strobe cycle
    assign wr_en = s.stb && s.we && !ack_q;

    always_ff @(posedge clk) begin
        for (int b = 0; b < wb_pkg::SEL_WIDTH; b++) begin
            if (wr_en && s.sel[b]) begin
                mem[s.adr[$clog2(wb_pkg::RAM_DEPTH)-1:0]][b*8 +: 8] <= s.dat_w[b*8 +: 8];
            end
        end
        rd_q <= mem[s.adr[$clog2(wb_pkg::RAM_DEPTH)-1:0]];
    end

    // Ack for exactly one cycle per request
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= s.stb && !ack_q;
        end
    end

    assign s.ack   = ack_q;
    assign s.dat_r = rd_q;

endmodule

`default_nettype wire

// ==== rtl/wb_cmp_timer.sv ====
// Compare timer with auto-reload, sticky match flag and
// Wishbone register access
`timescale 1ns/100ps
`default_nettype none

module wb_cmp_timer (
    input  wire logic clk,
    input  wire logic rst_n_i,
    wb_if.slave       s,
    output logic      irq_o
);

    logic                         en_q;
    logic                         reload_q;
    logic                         match_q;
    logic [wb_pkg::DAT_WIDTH-1:0] count_q;
    logic [wb_pkg::DAT_WIDTH-1:0] cmp_q;
    logic                         wr;
    logic                         hit;

    assign wr  = s.stb && s.we;
    assign hit = en_q && (count_q == cmp_q);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            en_q     <= 1'b0;
            reload_q <= 1'b0;
            match_q  <= 1'b0;
            count_q  <= '0;
            cmp_q    <= '0;
        end else begin
            if (wr && s.adr[1:0] == wb_pkg::TMR_CTRL) begin
                en_q     <= s.dat_w[wb_pkg::CTRL_EN_BIT];
                reload_q <= s.dat_w[wb_pkg::CTRL_RELOAD_BIT];
            end
            if (wr && s.adr[1:0] == wb_pkg::TMR_CMP) begin
                cmp_q <= s.dat_w;
            end

            // A load from the bus overrides counting
            if (wr && s.adr[1:0] == wb_pkg::TMR_COUNT) begin
                count_q <= s.dat_w;
            end else if (hit && reload_q) begin
                count_q <= '0;
            end else if (en_q) begin
                count_q <= count_q + 1'b1;
            end

            // New match wins over a clear in the same cycle
            if (hit) begin
                match_q <= 1'b1;
            end else if (wr && s.adr[1:0] == wb_pkg::TMR_STAT
                         && s.dat_w[wb_pkg::STAT_MATCH_BIT]) begin
                match_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (s.adr[1:0])
            wb_pkg::TMR_CTRL:  s.dat_r = wb_pkg::DAT_WIDTH'({reload_q, en_q});
            wb_pkg::TMR_COUNT: s.dat_r = count_q;
            wb_pkg::TMR_CMP:   s.dat_r = cmp_q;
            default:           s.dat_r = wb_pkg::DAT_WIDTH'(match_q);
        endcase
    end

    // Register access completes in the strobe cycle
    assign s.ack = s.stb;
    assign irq_o = match_q;

endmodule

`default_nettype wire

// ==== rtl/wb_subsys_top.sv ====
// Wishbone subsystem top: request slice, address decoder,
// scratch RAM and compare timer
`timescale 1ns/100ps
`default_nettype none

module wb_subsys_top (
    input  wire logic                         clk,
    input  wire logic                         rst_n_i,
    input  wire logic [wb_pkg::ADR_WIDTH-1:0] wb_adr_i,
    input  wire logic [wb_pkg::DAT_WIDTH-1:0] wb_dat_i,
    input  wire logic [wb_pkg::SEL_WIDTH-1:0] wb_sel_i,
    input  wire logic                         wb_we_i,
    input  wire logic                         wb_stb_i,
    output wire logic [wb_pkg::DAT_WIDTH-1:0] wb_dat_o,
    output wire logic                         wb_ack_o,
    output wire logic                         irq_o
);

    wb_if bus_up  ();
    wb_if bus_ram ();
    wb_if bus_tmr ();

    wb_req_slice u_req_slice (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .s_adr_i (wb_adr_i),
        .s_dat_i (wb_dat_i),
        .s_sel_i (wb_sel_i),
        .s_we_i  (wb_we_i),
        .s_stb_i (wb_stb_i),
        .s_dat_o (wb_dat_o),
        .s_ack_o (wb_ack_o),
        .m       (bus_up.master)
    );

    wb_addr_decoder u_addr_decoder (
        .s     (bus_up.slave),
        .m_ram (bus_ram.master),
        .m_tmr (bus_tmr.master)
    );

    wb_scratch_ram u_scratch_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .s       (bus_ram.slave)
    );

    wb_cmp_timer u_cmp_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .s       (bus_tmr.slave),
        .irq_o   (irq_o)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and synchronous reset generator
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset low for the first few rising edges
    initial begin
        rst_n_o <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/tb_checker.sv ====
// Bus monitor with read data compare, ack protocol and ack timeout checks
`timescale 1ns/100ps
`default_nettype none

module tb_checker #(
    parameter int ACK_LIMIT = 8
) (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire logic                         stb_i,
    input  wire logic                         we_i,
    input  wire logic                         ack_i,
    input  wire logic [wb_pkg::DAT_WIDTH-1:0] dat_i,
    input  wire logic [wb_pkg::DAT_WIDTH-1:0] exp_dat_i,
    input  wire logic                         check_i,
    output int                                data_errs_o,
    output int                                proto_errs_o
);

    int wait_cnt;

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (ack_i && !stb_i) begin
                $display("wb_ack_o was high at %0t while wb_stb_i was low", $time);
                proto_errs_o <= proto_errs_o + 1;
            end

            if (ack_i && stb_i && !we_i && check_i && dat_i !== exp_dat_i) begin
                $display("FAIL %0t wb_dat_o got %08h expected %08h",
                         $time, dat_i, exp_dat_i);
                data_errs_o <= data_errs_o + 1;
            end

            // Pending cycles of the current request
            if (stb_i && !ack_i) begin
                if (wait_cnt == ACK_LIMIT) begin
                    $display("No acknowledge within %0d cycles of wb_stb_i, at %0t",
                             ACK_LIMIT, $time);
                    proto_errs_o <= proto_errs_o + 1;
                end
                wait_cnt <= wait_cnt + 1;
            end else begin
                wait_cnt <= 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_top.sv ====
// Testbench top with stimulus table and loop, LFSR data source,
// DUT instance, checker and run timeout
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    localparam int          ACK_LIMIT    = 8;
    localparam int          IRQ_LIMIT    = 100;
    localparam logic [31:0] SEED         = 32'h5372;
    localparam logic [1:0]  ROW_BUS      = 2'd0;
    localparam logic [1:0]  ROW_IRQ_HIGH = 2'd1;
    localparam logic [1:0]  ROW_IRQ_LOW  = 2'd2;

    typedef struct packed {
        logic [1:0]                   kind;
        logic                         we;
        logic [wb_pkg::ADR_WIDTH-1:0] adr;
        logic [wb_pkg::DAT_WIDTH-1:0] wr_dat;
        logic [wb_pkg::SEL_WIDTH-1:0] sel;
        logic [wb_pkg::DAT_WIDTH-1:0] exp_dat;
        logic                         cmp;
        logic                         rnd;
    } row_t;

    logic                         clk;
    logic                         rst_n;
    logic [wb_pkg::ADR_WIDTH-1:0] wb_adr_i;
    logic [wb_pkg::DAT_WIDTH-1:0] wb_dat_i;
    logic [wb_pkg::SEL_WIDTH-1:0] wb_sel_i;
    logic                         wb_we_i;
    logic                         wb_stb_i;
    logic [wb_pkg::DAT_WIDTH-1:0] wb_dat_o;
    logic                         wb_ack_o;
    logic                         irq_o;
    logic [wb_pkg::DAT_WIDTH-1:0] exp_dat;
    logic                         check_en;
    logic [31:0]                  gen_state;
    logic [31:0]                  chk_state;
    row_t                         rows[$];
    int                           data_errs;
    int                           proto_errs;
    int                           seq_errs;
    int                           cycle_cnt;
    int                           cycle_limit;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    wb_subsys_top DUT (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_we_i  (wb_we_i),
        .wb_stb_i (wb_stb_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .irq_o    (irq_o)
    );

    tb_checker #(.ACK_LIMIT(ACK_LIMIT)) u_checker (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .stb_i        (wb_stb_i),
        .we_i         (wb_we_i),
        .ack_i        (wb_ack_o),
        .dat_i        (wb_dat_o),
        .exp_dat_i    (exp_dat),
        .check_i      (check_en),
        .data_errs_o  (data_errs),
        .proto_errs_o (proto_errs)
    );

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            lfsr_step = (state >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_step = state >> 1;
        end
    endfunction

    task automatic take_word(inout logic [31:0] state, output logic [31:0] word);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w     = {w[30:0], state[0]};
            state = lfsr_step(state);
        end
        word = w;
    endtask

    function automatic logic [wb_pkg::ADR_WIDTH-1:0] tmr_adr(input logic [1:0] offset);
        tmr_adr = wb_pkg::TMR_BASE + {{(wb_pkg::ADR_WIDTH-2){1'b0}}, offset};
    endfunction

    task automatic add_row(
        input logic [1:0]                   kind,
        input logic                         we,
        input logic [wb_pkg::ADR_WIDTH-1:0] adr,
        input logic [wb_pkg::DAT_WIDTH-1:0] wr_dat,
        input logic [wb_pkg::SEL_WIDTH-1:0] sel,
        input logic [wb_pkg::DAT_WIDTH-1:0] exp_val,
        input logic                         cmp,
        input logic                         rnd
    );
        rows.push_back(row_t'{kind, we, adr, wr_dat, sel, exp_val, cmp, rnd});
    endtask

    task automatic fill_table();
        // kind, we, adr, write data, sel, expected, compare, random
        add_row(ROW_BUS, 1'b1, 12'h000, 32'h0, 4'hF, 32'h0, 1'b0, 1'b1);
        add_row(ROW_BUS, 1'b1, 12'h0FF, 32'h0, 4'hF, 32'h0, 1'b0, 1'b1);
        add_row(ROW_BUS, 1'b1, 12'h080, 32'h0, 4'hF, 32'h0, 1'b0, 1'b1);
        add_row(ROW_BUS, 1'b1, 12'h03C, 32'h0, 4'hF, 32'h0, 1'b0, 1'b1);
        add_row(ROW_BUS, 1'b0, 12'h000, 32'h0, 4'hF, 32'h0, 1'b1, 1'b1);
        add_row(ROW_BUS, 1'b0, 12'h0FF, 32'h0, 4'hF, 32'h0, 1'b1, 1'b1);
        add_row(ROW_BUS, 1'b0, 12'h080, 32'h0, 4'hF, 32'h0, 1'b1, 1'b1);
        add_row(ROW_BUS, 1'b0, 12'h03C, 32'h0, 4'hF, 32'h0, 1'b1, 1'b1);
        // Byte lanes 0 and 2 replaced by the partial write
        add_row(ROW_BUS, 1'b1, 12'h010, 32'h1122_3344, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(ROW_BUS, 1'b1, 12'h010, 32'hAABB_CCDD, 4'b0101, 32'h0, 1'b0, 1'b0);
        add_row(ROW_BUS, 1'b0, 12'h010, 32'h0, 4'hF, 32'h11BB_33DD, 1'b1, 1'b0);
        // Unmapped write at 0x210 shares its low bits with RAM word 0x010
        add_row(ROW_BUS, 1'b0, 12'h200, 32'h0, 4'hF, 32'h0, 1'b1, 1'b0);
        add_row(ROW_BUS, 1'b1, 12'h210, 32'hDEAD_BEEF, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(ROW_BUS, 1'b0, 12'h010, 32'h0, 4'hF, 32'h11BB_33DD, 1'b1, 1'b0);
        // Registers hold their values while the timer is disabled
        add_row(ROW_BUS, 1'b1, tmr_adr(wb_pkg::TMR_CTRL), 32'h0, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(ROW_BUS, 1'b1, tmr_adr(wb_pkg::TMR_COUNT), 32'h1234, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(ROW_BUS, 1'b1, tmr_adr(wb_pkg::TMR_CMP), 32'hBEEF, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(ROW_BUS, 1'b0, tmr_adr(wb_pkg::TMR_COUNT), 32'h0, 4'hF, 32'h1234, 1'b1, 1'b0);
        add_row(ROW_BUS, 1'b0, tmr_adr(wb_pkg::TMR_CMP), 32'h0, 4'hF, 32'hBEEF, 1'b1, 1'b0);
        // Match at 20 with auto-reload off
        add_row(ROW_BUS, 1'b1, tmr_adr(wb_pkg::TMR_CMP), 32'd20, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(ROW_BUS, 1'b1, tmr_adr(wb_pkg::TMR_COUNT), 32'h0, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(ROW_BUS, 1'b1, tmr_adr(wb_pkg::TMR_CTRL), 32'h1, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(ROW_IRQ_HIGH, 1'b0, 12'h0, 32'h0, 4'h0, 32'h0, 1'b0, 1'b0);
        add_row(ROW_BUS, 1'b0, tmr_adr(wb_pkg::TMR_STAT), 32'h0, 4'hF, 32'h1, 1'b1, 1'b0);
        // Flag clear
        add_row(ROW_BUS, 1'b1, tmr_adr(wb_pkg::TMR_CTRL), 32'h0, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(ROW_BUS, 1'b1, tmr_adr(wb_pkg::TMR_STAT), 32'h1, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(ROW_IRQ_LOW, 1'b0, 12'h0, 32'h0, 4'h0, 32'h0, 1'b0, 1'b0);
        add_row(ROW_BUS, 1'b0, tmr_adr(wb_pkg::TMR_STAT), 32'h0, 4'hF, 32'h0, 1'b1, 1'b0);
    endtask

    // One classic transaction started right after a rising edge
    task automatic run_bus(input row_t r);
        logic [wb_pkg::DAT_WIDTH-1:0] wdat;
        logic [wb_pkg::DAT_WIDTH-1:0] edat;
        int                           n;
        wdat = r.wr_dat;
        edat = r.exp_dat;
        if (r.rnd && r.we) begin
            take_word(gen_state, wdat);
        end
        if (r.rnd && !r.we) begin
            take_word(chk_state, edat);
        end
        wb_adr_i <= r.adr;
        wb_dat_i <= wdat;
        wb_sel_i <= r.sel;
        wb_we_i  <= r.we;
        wb_stb_i <= 1'b1;
        exp_dat  <= edat;
        check_en <= r.cmp;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!wb_ack_o && n <= ACK_LIMIT);
        wb_stb_i <= 1'b0;
        check_en <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_irq_high();
        int n;
        n = 0;
        while (!irq_o && n < IRQ_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!irq_o) begin
            $display("irq_o did not rise within %0d cycles at %0t", IRQ_LIMIT, $time);
            seq_errs++;
        end
    endtask

    initial begin
        int total;
        wb_adr_i  <= '0;
        wb_dat_i  <= '0;
        wb_sel_i  <= '0;
        wb_we_i   <= 1'b0;
        wb_stb_i  <= 1'b0;
        exp_dat   <= '0;
        check_en  <= 1'b0;
        seq_errs  = 0;
        gen_state = SEED;
        chk_state = SEED;
        fill_table();
        cycle_limit = rows.size() * 12 + 200;

        @(posedge clk);
        while (!rst_n) begin
            @(posedge clk);
        end

        foreach (rows[i]) begin
            case (rows[i].kind)
                ROW_IRQ_HIGH: wait_irq_high();
                ROW_IRQ_LOW: begin
                    if (irq_o) begin
                        $display("irq_o still high after the flag clear at %0t", $time);
                        seq_errs++;
                    end
                end
                default: run_bus(rows[i]);
            endcase
        end

        repeat (2) @(posedge clk);
        total = data_errs + proto_errs + seq_errs;
        $display("Errors: %0d data, %0d protocol, %0d sequence", data_errs, proto_errs,
                 seq_errs);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Run limit from the table length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing the table", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/wb_pkg.sv
rtl/wb_if.sv
rtl/wb_req_slice.sv
rtl/wb_addr_decoder.sv
rtl/wb_scratch_ram.sv
rtl/wb_cmp_timer.sv
rtl/wb_subsys_top.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_top.sv

// ==== Makefile ====
TOP = tb_top

.PHONY: all lint clean

all:
	verilator --binary --timing --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
